//--- test/cache_stimulus.dat
# w tid addr wdata | v d tag ldata | rd rdata | fill faddr fdata | wb waddr wdata | fetch faddr | stall
# all hex; stall bit 0 read sink, bit 1 fill sink, bit 2 command sink may stall at random
0 1 0a35 00000000 1 0 02 deadbeef 1 deadbeef 0 0000 00000000 0 0000 00000000 0 0000 0
0 2 1470 00000000 1 1 05 12345678 1 12345678 0 0000 00000000 0 0000 00000000 0 0000 0
0 3 4404 00000000 1 0 12 0badf00d 0 00000000 0 0000 00000000 0 0000 00000000 1 4404 0
0 4 a9c0 00000000 1 1 03 cafe0001 0 00000000 0 0000 00000000 1 0dc0 cafe0001 1 a9c0 0
1 5 fc08 55aa55aa 1 0 3f 00000000 0 00000000 1 fc08 55aa55aa 0 0000 00000000 0 0000 0
1 6 7010 01020304 1 0 1d 99999999 0 00000000 1 7010 01020304 0 0000 00000000 0 0000 0
1 7 2520 a5a5a5a5 1 1 0e 77777777 0 00000000 1 2520 a5a5a5a5 1 3920 77777777 0 0000 0
0 8 cc44 00000000 0 0 33 11111111 0 00000000 0 0000 00000000 0 0000 00000000 1 cc44 0
1 9 cc48 22222222 0 0 33 33333333 0 00000000 1 cc48 22222222 0 0000 00000000 0 0000 0
1 a 0a3c 0f0f0f0f 1 1 02 44444444 0 00000000 1 0a3c 0f0f0f0f 0 0000 00000000 0 0000 0
0 b 1404 00000000 1 1 06 88880001 0 00000000 0 0000 00000000 1 1804 88880001 1 1404 7
1 c 4410 10101010 1 1 10 66660002 0 00000000 1 4410 10101010 1 4010 66660002 0 0000 7
0 d a800 00000000 1 0 2a 13579bdf 1 13579bdf 0 0000 00000000 0 0000 00000000 0 0000 7
0 e fc20 00000000 1 0 01 00000001 0 00000000 0 0000 00000000 0 0000 00000000 1 fc20 7
1 f 7014 2468ace0 1 1 1c 55555555 0 00000000 1 7014 2468ace0 0 0000 00000000 0 0000 7
0 0 2400 00000000 1 1 3f fedcba98 0 00000000 0 0000 00000000 1 fc00 fedcba98 1 2400 7
1 1 cc7f 87654321 1 1 32 0a0a0a0a 0 00000000 1 cc7f 87654321 1 c87f 0a0a0a0a 0 0000 7
0 2 0800 00000000 1 1 02 abcdef01 1 abcdef01 0 0000 00000000 0 0000 00000000 0 0000 7
0 3 4bff 00000000 1 1 00 31415926 0 00000000 0 0000 00000000 1 03ff 31415926 1 4bff 7
1 4 1470 27182818 0 0 05 00000000 0 00000000 1 1470 27182818 0 0000 00000000 0 0000 7
0 5 a9c0 00000000 1 0 2a 0000beef 1 0000beef 0 0000 00000000 0 0000 00000000 0 0000 7
1 6 0a35 1badcafe 1 0 02 00000000 0 00000000 1 0a35 1badcafe 0 0000 00000000 0 0000 7
0 7 7000 00000000 1 0 1b 12121212 0 00000000 0 0000 00000000 0 0000 00000000 1 7000 7
1 8 25a0 0c0c0c0c 1 1 0a 3c3c3c3c 0 00000000 1 25a0 0c0c0c0c 1 29a0 3c3c3c3c 0 0000 7
0 9 fc08 00000000 1 0 3f 55aa55aa 1 55aa55aa 0 0000 00000000 0 0000 00000000 0 0000 7
0 a cc44 00000000 1 1 2f 90909090 0 00000000 0 0000 00000000 1 bc44 90909090 1 cc44 7

//--- flist.f
hdl/dram_cache_pkg.sv
hdl/req_queue.sv
hdl/tag_compare.sv
hdl/mem_cmd_sequencer.sv
hdl/dram_cache_top.sv
test/tb_checker.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_top -f flist.f -o sim
./obj_dir/sim | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- test/tb_top.sv
module tb_top;
	timeunit 1ns;
	timeprecision 100ps;
	import dram_cache_pkg::*;

	localparam int PERIOD       = 40;
	localparam int RESET_CYCLES = 4;
	localparam int MAX_TX       = 64;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     req_valid_i;
	logic     req_ready_o;
	req_t     req_i;
	logic     line_valid_i;
	logic     line_ready_o;
	line_t    line_i;
	logic     rd_valid_o;
	logic     rd_ready_i = 1'b0;
	rd_resp_t rd_resp_o;
	logic     fill_valid_o;
	logic     fill_ready_i = 1'b0;
	fill_t    fill_o;
	logic     cmd_valid_o;
	logic     cmd_ready_i = 1'b0;
	mem_cmd_t cmd_o;

	req_t       req_mem [MAX_TX];
	line_t      line_mem [MAX_TX];
	logic [2:0] stall_mem [MAX_TX];
	logic [2:0] stall_mask = 3'b000; // bit 0 read, bit 1 fill, bit 2 command sink
	int         tx_count = 0;
	int         load_errors = 0;
	int         total_errors;
	logic       loaded = 1'b0;
	integer     seed = 72;

	always #(PERIOD / 2) clk = ~clk;

	dram_cache_top #(.DEPTH(4)) DUT (.*);

	tb_checker chk (.*);

	// one transaction per data line, expectations go straight to the checker
	task automatic load_stimulus();
		int          fd;
		int          n;
		string       text;
		logic [31:0] f [19];
		rd_resp_t    r;
		fill_t       fl;
		mem_cmd_t    c;
		fd = $fopen("test/cache_stimulus.dat", "r");
		if (fd == 0) begin
			$display("could not open test/cache_stimulus.dat");
			load_errors++;
			return;
		end
		while (!$feof(fd)) begin
			text = "";
			void'($fgets(text, fd));
			if (text.len() < 2 || text.getc(0) == "#")
				continue; // blank or comment
			n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
			if (n != 19 || tx_count == MAX_TX) begin
				$display("stimulus line could not be used: %s", text);
				load_errors++;
				continue;
			end
			req_mem[tx_count].write  = f[0][0];
			req_mem[tx_count].tid    = tid_t'(f[1]);
			req_mem[tx_count].addr   = addr_t'(f[2]);
			req_mem[tx_count].wdata  = f[3];
			line_mem[tx_count].valid = f[4][0];
			line_mem[tx_count].dirty = f[5][0];
			line_mem[tx_count].tag   = tag_t'(f[6]);
			line_mem[tx_count].data  = f[7];
			stall_mem[tx_count]      = f[18][2:0];
			r.tid   = tid_t'(f[1]);
			r.data  = f[9];
			fl.addr = addr_t'(f[11]);
			fl.data = f[12];
			if (f[8][0])
				chk.rd_q.push_back(r);
			if (f[10][0])
				chk.fill_q.push_back(fl);
			c.tid = tid_t'(f[1]);
			if (f[13][0]) begin // writeback goes ahead of the fetch
				c.is_write = 1'b1;
				c.addr     = addr_t'(f[14]);
				c.data     = f[15];
				chk.cmd_q.push_back(c);
			end
			if (f[16][0]) begin
				c.is_write = 1'b0;
				c.addr     = addr_t'(f[17]);
				c.data     = '0;
				chk.cmd_q.push_back(c);
			end
			tx_count++;
		end
		$fclose(fd);
	endtask

	task automatic send_requests();
		for (int i = 0; i < tx_count; i++) begin
			@(posedge clk);
			#2;
			req_valid_i = 1'b1;
			req_i       = req_mem[i];
			do
				@(negedge clk); // ready is settled mid-cycle
			while (!req_ready_o);
		end
		@(posedge clk);
		#2;
		req_valid_i = 1'b0;
	endtask

	task automatic send_lines();
		for (int i = 0; i < tx_count; i++) begin
			@(posedge clk);
			#2;
			line_valid_i = 1'b1;
			line_i       = line_mem[i];
			stall_mask  <= stall_mem[i];
			do
				@(negedge clk);
			while (!line_ready_o);
		end
		@(posedge clk);
		#2;
		line_valid_i = 1'b0;
	endtask

	// sinks stall at random only where the current pattern allows it
	always @(posedge clk) begin
		#2;
		rd_ready_i   = stall_mask[0] ? (($random(seed) % 2) == 0) : 1'b1;
		fill_ready_i = stall_mask[1] ? (($random(seed) % 2) == 0) : 1'b1;
		cmd_ready_i  = stall_mask[2] ? (($random(seed) % 2) == 0) : 1'b1;
	end

	initial begin
		rst_n        = 1'b0;
		req_valid_i  = 1'b0;
		req_i        = '0;
		line_valid_i = 1'b0;
		line_i       = '0;
		load_stimulus();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		if (tx_count > 0) begin
			fork
				send_requests();
				send_lines();
			join
			while (chk.rd_q.size() + chk.fill_q.size() + chk.cmd_q.size() != 0)
				@(posedge clk);
		end
		repeat (10) @(posedge clk); // room for stray outputs
		total_errors = load_errors + chk.errors;
		$display("errors: %0d (stimulus %0d, checker %0d) over %0d transactions",
			total_errors, load_errors, chk.errors, tx_count);
		if (total_errors == 0 && tx_count > 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// budget of 20 cycles per transaction on top of reset
	initial begin
		wait (loaded);
		#((RESET_CYCLES + 20 + tx_count * 20) * PERIOD);
		$display("timeout: the run did not drain all %0d transactions in time", tx_count);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- test/tb_checker.sv
module tb_checker (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     req_ready_o,
	input logic                     line_ready_o,
	input logic                     rd_valid_o,
	input logic                     rd_ready_i,
	input dram_cache_pkg::rd_resp_t rd_resp_o,
	input logic                     fill_valid_o,
	input logic                     fill_ready_i,
	input dram_cache_pkg::fill_t    fill_o,
	input logic                     cmd_valid_o,
	input logic                     cmd_ready_i,
	input dram_cache_pkg::mem_cmd_t cmd_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import dram_cache_pkg::*;

	rd_resp_t rd_q [$];
	fill_t    fill_q [$];
	mem_cmd_t cmd_q [$];
	int       errors = 0;

	// sampled mid-cycle, a transfer completes at the next rising edge
	always @(negedge clk) begin
		rd_resp_t r;
		fill_t    f;
		mem_cmd_t c;
		if (!rst_n) begin
			if (rd_valid_o || fill_valid_o || cmd_valid_o || req_ready_o || line_ready_o) begin
				$display("ERR %0t: valid or ready output high during reset", $time);
				errors++;
			end
		end else begin
			if (rd_valid_o && rd_ready_i) begin
				if (rd_q.size() == 0) begin
					$display("read response for tid %0h at %0t arrived when none was expected",
						rd_resp_o.tid, $time);
					errors++;
				end else begin
					r = rd_q.pop_front();
					if (rd_resp_o != r) begin
						$display("ERR %0t: read tid %0h data %h, expected tid %0h data %h",
							$time, rd_resp_o.tid, rd_resp_o.data, r.tid, r.data);
						errors++;
					end
				end
			end
			if (fill_valid_o && fill_ready_i) begin
				if (fill_q.size() == 0) begin
					$display("fill to %h at %0t arrived when none was expected",
						fill_o.addr, $time);
					errors++;
				end else begin
					f = fill_q.pop_front();
					if (fill_o != f) begin
						$display("ERR %0t: fill addr %h data %h, expected addr %h data %h",
							$time, fill_o.addr, fill_o.data, f.addr, f.data);
						errors++;
					end
				end
			end
			if (cmd_valid_o && cmd_ready_i) begin
				if (cmd_q.size() == 0) begin
					$display("memory command to %h at %0t arrived when none was expected",
						cmd_o.addr, $time);
					errors++;
				end else begin
					c = cmd_q.pop_front();
					if (cmd_o != c) begin
						// fields are wr, tid, addr, data
						$display("ERR %0t: cmd %b %0h %h %h, expected %b %0h %h %h",
							$time, cmd_o.is_write, cmd_o.tid, cmd_o.addr, cmd_o.data,
							c.is_write, c.tid, c.addr, c.data);
						errors++;
					end
				end
			end
		end
	end

endmodule

//--- hdl/dram_cache_top.sv
module dram_cache_top #(
	parameter int DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req_valid_i,
	output logic                     req_ready_o,
	input  dram_cache_pkg::req_t     req_i,
	input  logic                     line_valid_i,
	output logic                     line_ready_o,
	input  dram_cache_pkg::line_t    line_i,
	output logic                     rd_valid_o,
	input  logic                     rd_ready_i,
	output dram_cache_pkg::rd_resp_t rd_resp_o,
	output logic                     fill_valid_o,
	input  logic                     fill_ready_i,
	output dram_cache_pkg::fill_t    fill_o,
	output logic                     cmd_valid_o,
	input  logic                     cmd_ready_i,
	output dram_cache_pkg::mem_cmd_t cmd_o
);
	import dram_cache_pkg::*;

	logic  q_valid;
	logic  q_ready;
	req_t  q_req;
	logic  miss_valid;
	logic  miss_ready;
	miss_t miss;

	req_queue #(.DEPTH(DEPTH)) u_req_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_i  (req_valid_i),
		.in_ready_o  (req_ready_o),
		.in_i        (req_i),
		.out_valid_o (q_valid),
		.out_ready_i (q_ready),
		.out_o       (q_req)
	);

	// one request in flight here, lines arrive in request order
	tag_compare u_tag_compare (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_valid_i  (q_valid),
		.req_ready_o  (q_ready),
		.req_i        (q_req),
		.line_valid_i (line_valid_i),
		.line_ready_o (line_ready_o),
		.line_i       (line_i),
		.rd_valid_o   (rd_valid_o),
		.rd_ready_i   (rd_ready_i),
		.rd_resp_o    (rd_resp_o),
		.fill_valid_o (fill_valid_o),
		.fill_ready_i (fill_ready_i),
		.fill_o       (fill_o),
		.miss_valid_o (miss_valid),
		.miss_ready_i (miss_ready),
		.miss_o       (miss)
	);

	mem_cmd_sequencer u_mem_cmd_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.miss_valid_i (miss_valid),
		.miss_ready_o (miss_ready),
		.miss_i       (miss),
		.cmd_valid_o  (cmd_valid_o),
		.cmd_ready_i  (cmd_ready_i),
		.cmd_o        (cmd_o)
	);

endmodule

//--- hdl/mem_cmd_sequencer.sv
module mem_cmd_sequencer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     miss_valid_i,
	output logic                     miss_ready_o,
	input  dram_cache_pkg::miss_t    miss_i,
	output logic                     cmd_valid_o,
	input  logic                     cmd_ready_i,
	output dram_cache_pkg::mem_cmd_t cmd_o
);
	import dram_cache_pkg::*;

	seq_state_e state;
	seq_state_e state_n;
	miss_t      miss_q;
	logic       take;
	logic       cmd_fire;

	assign miss_ready_o = (state == SQ_IDLE);
	assign take         = miss_valid_i && miss_ready_o;
	assign cmd_valid_o  = (state != SQ_IDLE);
	assign cmd_fire     = cmd_valid_o && cmd_ready_i;

	// command is a pure function of state and the stored record
	always_comb begin
		cmd_o     = '0;
		cmd_o.tid = miss_q.tid;
		if (state == SQ_WB) begin
			cmd_o.is_write = 1'b1;
			cmd_o.addr     = miss_q.wb_addr;
			cmd_o.data     = miss_q.wb_data;
		end else begin
			cmd_o.is_write = 1'b0;
			cmd_o.addr     = miss_q.fetch_addr;
		end
	end

	always_comb begin
		state_n = state;
		case (state)
			SQ_IDLE: begin
				if (take) begin
					if (miss_i.wb_en)
						state_n = SQ_WB; // writeback goes out first
					else if (miss_i.fetch_en)
						state_n = SQ_FETCH;
				end
			end
			SQ_WB: begin
				if (cmd_fire)
					state_n = miss_q.fetch_en ? SQ_FETCH : SQ_IDLE;
			end
			SQ_FETCH: begin
				if (cmd_fire)
					state_n = SQ_IDLE;
			end
			default: state_n = SQ_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= SQ_IDLE;
		else
			state <= state_n;
	end

	always_ff @(posedge clk) begin
		if (take)
			miss_q <= miss_i;
	end

	a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd_valid_o && !cmd_ready_i) |=> (cmd_valid_o && $stable(cmd_o)));

endmodule

//--- hdl/tag_compare.sv
module tag_compare (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req_valid_i,
	output logic                     req_ready_o,
	input  dram_cache_pkg::req_t     req_i,
	input  logic                     line_valid_i,
	output logic                     line_ready_o,
	input  dram_cache_pkg::line_t    line_i,
	output logic                     rd_valid_o,
	input  logic                     rd_ready_i,
	output dram_cache_pkg::rd_resp_t rd_resp_o,
	output logic                     fill_valid_o,
	input  logic                     fill_ready_i,
	output dram_cache_pkg::fill_t    fill_o,
	output logic                     miss_valid_o,
	input  logic                     miss_ready_i,
	output dram_cache_pkg::miss_t    miss_o
);
	import dram_cache_pkg::*;

	cmp_state_e state;
	cmp_state_e state_n;
	logic       accept;
	logic       hit;
	logic       fill_done;
	logic       fill_done_n;
	logic       miss_done;
	logic       miss_done_n;
	logic       rd_done_n;
	rd_resp_t   rd_resp_q;
	fill_t      fill_q;
	miss_t      miss_q;
	miss_t      miss_n;

	// request and line are taken together or not at all
	assign accept       = (state == S_IDLE) && req_valid_i && line_valid_i;
	assign req_ready_o  = accept;
	assign line_ready_o = accept;

	assign hit = line_i.valid && (line_i.tag == req_i.addr[ADDR_W-1 -: TAG_W]);

	// miss record built straight from the incoming pair
	always_comb begin
		miss_n            = '0;
		miss_n.fetch_en   = !req_i.write;
		miss_n.wb_en      = line_i.dirty;
		miss_n.tid        = req_i.tid;
		miss_n.fetch_addr = req_i.addr;
		miss_n.wb_addr    = {line_i.tag, req_i.addr[INDEX_W+OFFSET_W-1:0]};
		miss_n.wb_data    = line_i.data;
	end

	assign rd_valid_o   = (state == S_RHIT);
	assign fill_valid_o = ((state == S_WHIT) || (state == S_WMISS)) && !fill_done;
	assign miss_valid_o = ((state == S_RMISS) || (state == S_WMISS)) && !miss_done;

	assign rd_resp_o = rd_resp_q;
	assign fill_o    = fill_q;
	assign miss_o    = miss_q;

	always_comb begin
		state_n     = state;
		fill_done_n = fill_done | (fill_valid_o & fill_ready_i);
		miss_done_n = miss_done | (miss_valid_o & miss_ready_i);
		rd_done_n   = rd_valid_o & rd_ready_i;

		case (state)
			S_IDLE: begin
				if (accept) begin
					if (req_i.write)
						state_n = hit ? S_WHIT : S_WMISS;
					else
						state_n = hit ? S_RHIT : S_RMISS;
					fill_done_n = !req_i.write; // only writes owe a fill
					// reads always owe the record on a miss, writes only if dirty
					miss_done_n = hit || (req_i.write && !line_i.dirty);
				end
			end
			S_RHIT: begin
				if (rd_done_n)
					state_n = S_IDLE;
			end
			S_RMISS: begin
				if (miss_done_n)
					state_n = S_IDLE;
			end
			S_WHIT: begin
				if (fill_done_n)
					state_n = S_IDLE;
			end
			S_WMISS: begin
				if (fill_done_n && miss_done_n)
					state_n = S_IDLE;
			end
			default: state_n = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			fill_done <= 1'b0;
			miss_done <= 1'b0;
		end else begin
			state     <= state_n;
			fill_done <= fill_done_n;
			miss_done <= miss_done_n;
		end
	end

	// payload captured on accept, held through the case state
	always_ff @(posedge clk) begin
		if (accept) begin
			rd_resp_q.tid  <= req_i.tid;
			rd_resp_q.data <= line_i.data;
			fill_q.addr    <= req_i.addr;
			fill_q.data    <= req_i.wdata;
			miss_q         <= miss_n;
		end
	end

	// each owed output holds its payload until the sink takes it
	a_rd_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_valid_o && !rd_ready_i) |=> (rd_valid_o && $stable(rd_resp_o)));

	a_fill_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(fill_valid_o && !fill_ready_i) |=> (fill_valid_o && $stable(fill_o)));

	a_miss_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(miss_valid_o && !miss_ready_i) |=> (miss_valid_o && $stable(miss_o)));

endmodule

//--- hdl/req_queue.sv
module req_queue #(
	parameter int DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid_i,
	output logic                 in_ready_o,
	input  dram_cache_pkg::req_t in_i,
	output logic                 out_valid_o,
	input  logic                 out_ready_i,
	output dram_cache_pkg::req_t out_o
);
	import dram_cache_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	req_t             mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_n;
	logic             ready_q;
	logic             push;
	logic             pop;

	// wrap for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push    = in_valid_i && ready_q;
	assign pop     = out_valid_o && out_ready_i;
	assign count_n = count + CNT_W'(push) - CNT_W'(pop);

	assign in_ready_o  = ready_q; // registered, low through reset
	assign out_valid_o = (count != '0);
	assign out_o       = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			ready_q <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count   <= count_n;
			ready_q <= (count_n != CNT_W'(DEPTH)); // look ahead one cycle
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_i;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (count < CNT_W'(DEPTH)));

	a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_o)));

endmodule

//--- hdl/dram_cache_pkg.sv
package dram_cache_pkg;

	// address split is tag | index | offset
	localparam int ADDR_W   = 16;
	localparam int DATA_W   = 32;
	localparam int TID_W    = 4;
	localparam int TAG_W    = 6;
	localparam int INDEX_W  = 6;
	localparam int OFFSET_W = 4;

	typedef logic [ADDR_W-1:0] addr_t; // byte address
	typedef logic [DATA_W-1:0] data_t; // one cache word
	typedef logic [TID_W-1:0]  tid_t;
	typedef logic [TAG_W-1:0]  tag_t;

	typedef struct packed {
		logic  write; // 1 = write, 0 = read
		tid_t  tid;
		addr_t addr;
		data_t wdata; // only meaningful for writes
	} req_t;

	// line as returned by the memory controller
	typedef struct packed {
		logic  valid;
		logic  dirty;
		tag_t  tag;
		data_t data;
	} line_t;

	typedef struct packed {
		tid_t  tid;
		data_t data;
	} rd_resp_t;

	typedef struct packed {
		addr_t addr;
		data_t data;
	} fill_t;

	typedef struct packed {
		logic  fetch_en; // read miss, line has to come in
		logic  wb_en;    // victim was dirty
		tid_t  tid;
		addr_t fetch_addr;
		addr_t wb_addr;  // victim tag with request index/offset
		data_t wb_data;
	} miss_t;

	typedef struct packed {
		logic  is_write;
		tid_t  tid;
		addr_t addr;
		data_t data;
	} mem_cmd_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_RHIT,
		S_RMISS,
		S_WHIT,
		S_WMISS
	} cmp_state_e;

	typedef enum logic [1:0] {
		SQ_IDLE,
		SQ_WB,
		SQ_FETCH
	} seq_state_e;

endpackage
